// File: list.f
+incdir+design
design/pattern_gen_pkg.sv
design/gen_csr_wb.sv
design/seq_frame_gen.sv
design/frame_monitor.sv
design/pattern_gen_top.sv
test/stream_checker.sv
test/tb_pattern_gen.sv

// File: run_sim.sh
#!/bin/sh
# build and run the pattern generator testbench with verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary -f list.f --top-module tb_pattern_gen -Mdir obj_dir

# the log decides the result, so a nonzero exit from the run is not fatal here
./obj_dir/Vtb_pattern_gen > sim.log 2>&1 || true
cat sim.log

if grep -qx "Done: no errors" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

// File: test/tb_pattern_gen.sv
// pattern generator testbench
// drives wishbone register accesses and a random stream ready,
// starts random frames and leaves the comparing to the checker

`include "pattern_gen_config.svh"

module tb_pattern_gen
    import pattern_gen_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [31:0] SEED = 32'h026c_ee44;
    localparam int WB_TIMEOUT    = 16;
    localparam int VALID_TIMEOUT = 20;
    localparam int FRAME_TIMEOUT = 400;

    logic         clock;
    logic         rst_n;
    wb_req_t      wb_req;
    logic         wb_ack;
    pg_data_t     wb_dat_r;
    stream_beat_t out_beat;
    logic         out_valid;
    logic         out_ready;

    // published to the checker
    gen_cfg_t     frame_cfg;
    logic         frame_expected;
    logic         busy_expected;
    int           test_id;
    int           error_count;
    int           check_count;
    int           test_count;

    logic [31:0]  seed;
    logic [31:0]  ready_state;
    // ready pattern held low (0) or high (1) or random (2)
    int           ready_mode;

    pattern_gen_top UUT (
        .clock     (clock),
        .rst_n     (rst_n),
        .wb_req    (wb_req),
        .wb_ack    (wb_ack),
        .wb_dat_r  (wb_dat_r),
        .out_beat  (out_beat),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

    stream_checker u_check (
        .clock          (clock),
        .rst_n          (rst_n),
        .wb_req         (wb_req),
        .wb_ack         (wb_ack),
        .wb_dat_r       (wb_dat_r),
        .out_beat       (out_beat),
        .out_valid      (out_valid),
        .out_ready      (out_ready),
        .frame_cfg      (frame_cfg),
        .frame_expected (frame_expected),
        .busy_expected  (busy_expected),
        .test_id        (test_id),
        .error_count    (error_count),
        .check_count    (check_count),
        .test_count     (test_count)
    );

    always #2 clock = ~clock;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic next_rand(output logic [31:0] value);
        seed  = xorshift32(seed);
        value = seed;
    endtask

    // consumer ready is high about 70 percent of the time in random mode
    always @(posedge clock) begin : drive_ready
        int mode_now;
        // mode taken on the edge, before the stimulus moves it
        mode_now = ready_mode;
        #1;
        if (mode_now == 0) begin
            out_ready = 1'b0;
        end else if (mode_now == 1) begin
            out_ready = 1'b1;
        end else begin
            ready_state = xorshift32(ready_state);
            out_ready   = (ready_state % 10) < 7;
        end
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Done: errors found");
        $finish;
    endtask

    // one wishbone classic cycle that drops stb once ack is seen
    task automatic bus_cycle(input logic we, input pg_addr_t adr, input pg_data_t dat);
        logic acked;
        acked = 1'b0;
        @(posedge clock);
        #1;
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we  = we;
        wb_req.adr = adr;
        wb_req.dat = dat;
        for (int n = 0; n < WB_TIMEOUT; n++) begin
            @(posedge clock);
            #1;
            if (wb_ack) begin
                acked = 1'b1;
                break;
            end
        end
        if (!acked) begin
            abort_run($sformatf("no wishbone ack for register %0d", adr));
        end else begin
            wb_req = '0;
        end
    endtask

    task automatic write_reg(input pg_addr_t adr, input pg_data_t dat);
        bus_cycle(1'b1, adr, dat);
    endtask

    task automatic read_reg(input pg_addr_t adr);
        bus_cycle(1'b0, adr, '0);
    endtask

    task automatic start_frame(input pg_data_t start, input pg_len_t length, input logic mode);
        frame_cfg.start       = start;
        frame_cfg.length      = length;
        frame_cfg.repeat_mode = mode;
        write_reg(`PG_REG_START, start);
        write_reg(`PG_REG_LENGTH, length);
        frame_expected = 1'b1;
        write_reg(`PG_REG_CTRL, pg_data_t'({mode, 1'b1}));
    endtask

    task automatic wait_first_beat();
        logic seen;
        seen = 1'b0;
        for (int n = 0; n < VALID_TIMEOUT; n++) begin
            @(posedge clock);
            if (out_valid) begin
                seen = 1'b1;
                break;
            end
        end
        if (!seen) begin
            abort_run("frame did not start after the go write");
        end else begin
            #1;
        end
    endtask

    // ends on the edge where the last beat transfers
    task automatic wait_frame_end();
        logic seen;
        seen = 1'b0;
        for (int n = 0; n < FRAME_TIMEOUT; n++) begin
            @(posedge clock);
            if (out_valid && out_ready && out_beat.last) begin
                seen = 1'b1;
                break;
            end
        end
        if (!seen) begin
            abort_run("frame did not finish in time");
        end else begin
            #1;
            frame_expected = 1'b0;
        end
    endtask

    // mode_sel picks counting (0) or repeat (1) or random (2)
    task automatic run_frames(input int count, input int mode_sel);
        logic [31:0] r_start;
        logic [31:0] r_len;
        logic [31:0] r_mode;
        for (int i = 0; i < count; i++) begin
            next_rand(r_start);
            next_rand(r_len);
            next_rand(r_mode);
            start_frame(r_start, r_len % 21, (mode_sel == 2) ? r_mode[3] : mode_sel[0]);
            wait_frame_end();
        end
    endtask

    initial begin
        logic [31:0] new_start;
        logic [31:0] new_len;
        logic [31:0] new_mode;
        clock          = 1'b0;
        rst_n          = 1'b0;
        wb_req         = '0;
        out_ready      = 1'b0;
        ready_mode     = 0;
        frame_cfg      = '0;
        frame_expected = 1'b0;
        busy_expected  = 1'b0;
        test_id        = 1;
        seed           = SEED;
        ready_state    = SEED ^ 32'h9e37_79b9;
        repeat (2) @(posedge clock);
        #1;
        rst_n = 1'b1;

        // everything reads zero out of reset
        repeat (2) @(posedge clock);
        for (int a = 0; a < 7; a++) begin
            read_reg(pg_addr_t'(a));
        end

        test_id    = 2;
        ready_mode = 1;
        // crosses the 2^32 wrap
        start_frame(32'hffff_fffa, 32'd12, 1'b0);
        wait_frame_end();
        run_frames(6, 0);

        test_id = 3;
        run_frames(5, 1);

        test_id    = 4;
        ready_mode = 2;
        run_frames(8, 2);

        // stall the frame so it is surely running during the writes
        test_id    = 5;
        ready_mode = 0;
        next_rand(new_start);
        next_rand(new_len);
        start_frame(new_start, 6 + (new_len % 10), 1'b0);
        wait_first_beat();
        busy_expected = 1'b1;
        read_reg(`PG_REG_STATUS);
        next_rand(new_start);
        next_rand(new_len);
        next_rand(new_mode);
        new_len = new_len % 21;
        write_reg(`PG_REG_START, new_start);
        write_reg(`PG_REG_LENGTH, new_len);
        write_reg(`PG_REG_CTRL, pg_data_t'({new_mode[5], 1'b1}));
        read_reg(`PG_REG_STATUS);
        ready_mode = 2;
        wait_frame_end();
        // a stray restart would show up here
        repeat (6) @(posedge clock);
        #1;
        busy_expected = 1'b0;
        read_reg(`PG_REG_STATUS);
        frame_cfg.start       = new_start;
        frame_cfg.length      = new_len;
        frame_cfg.repeat_mode = new_mode[5];
        frame_expected        = 1'b1;
        write_reg(`PG_REG_CTRL, pg_data_t'({new_mode[5], 1'b1}));
        wait_frame_end();

        test_id    = 6;
        ready_mode = 1;
        repeat (4) @(posedge clock);
        for (int a = 0; a < 7; a++) begin
            read_reg(pg_addr_t'(a));
        end

        test_id = 0;
        repeat (3) @(posedge clock);
        $display("tests %0d, checks %0d, errors %0d", test_count, check_count, error_count);
        if (error_count == 0 && check_count > 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// File: test/stream_checker.sv
// stream and register checker
// watches the pattern generator ports, runs a reference model of the
// frame sequence, the registers and the counters, and reports each test

`include "pattern_gen_config.svh"

module stream_checker
    import pattern_gen_pkg::*;
(
    input  logic         clock,
    input  logic         rst_n,
    input  wb_req_t      wb_req,
    input  logic         wb_ack,
    input  pg_data_t     wb_dat_r,
    input  stream_beat_t out_beat,
    input  logic         out_valid,
    input  logic         out_ready,
    input  gen_cfg_t     frame_cfg,
    input  logic         frame_expected,
    input  logic         busy_expected,
    input  int           test_id,
    output int           error_count,
    output int           check_count,
    output int           test_count
);
    timeunit 1ns;
    timeprecision 1ps;

    // model of the frame in flight
    logic         in_frame;
    logic         m_mode;
    pg_data_t     m_data;
    pg_len_t      m_total;
    pg_len_t      m_idx;
    pg_data_t     m_sum;
    logic         exp_last;
    pg_data_t     sum_new;
    // model of the monitor counters
    pg_data_t     m_frames;
    pg_data_t     m_beats;
    pg_data_t     m_csum;
    // shadow of the writable registers
    pg_data_t     s_start;
    pg_len_t      s_length;
    logic         s_mode;
    // ack the slave owes on this edge
    logic         ack_exp;
    // read waiting for its ack
    logic         rd_wait;
    pg_addr_t     rd_adr;
    pg_data_t     rd_exp;
    // beat seen under back-pressure
    logic         held_valid;
    stream_beat_t held_beat;
    logic         rst_checked;

    int errors = 0;
    int checks = 0;
    int tests = 0;
    int prev_id = 0;
    int test_checks = 0;
    int test_errors = 0;

    assign error_count = errors;
    assign check_count = checks;
    assign test_count  = tests;

    function automatic string test_label(input int id);
        case (id)
            1: return "reset";
            2: return "counting";
            3: return "repeat";
            4: return "backpressure";
            5: return "busy";
            6: return "counters";
            default: return "none";
        endcase
    endfunction

    function automatic string reg_name(input pg_addr_t adr);
        case (adr)
            `PG_REG_START:  return "START";
            `PG_REG_LENGTH: return "LENGTH";
            `PG_REG_CTRL:   return "CTRL";
            `PG_REG_STATUS: return "STATUS";
            `PG_REG_FRAMES: return "FRAMES";
            `PG_REG_BEATS:  return "BEATS";
            `PG_REG_CSUM:   return "CSUM";
            default:        return "unmapped";
        endcase
    endfunction

    // register map as seen by software
    function automatic pg_data_t expected_read(input pg_addr_t adr);
        case (adr)
            `PG_REG_START:  return s_start;
            `PG_REG_LENGTH: return s_length;
            // go bit never reads back
            `PG_REG_CTRL:   return pg_data_t'({s_mode, 1'b0});
            `PG_REG_STATUS: return pg_data_t'(busy_expected);
            `PG_REG_FRAMES: return m_frames;
            `PG_REG_BEATS:  return m_beats;
            `PG_REG_CSUM:   return m_csum;
            default:        return '0;
        endcase
    endfunction

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks      = checks + 1;
        test_checks = test_checks + 1;
        if (actual !== expected) begin
            errors      = errors + 1;
            test_errors = test_errors + 1;
            $display("** Error: %s, %s: expected %h, actual %h",
                     test_label(prev_id), what, expected, actual);
        end
    endtask

    task automatic report_fault(input string what);
        errors      = errors + 1;
        test_errors = test_errors + 1;
        $display("%s test went wrong: %s", test_label(prev_id), what);
    endtask

    task automatic report_test();
        $display("test %0d %s: %s, %0d checks, %0d errors", prev_id, test_label(prev_id),
                 (test_errors == 0) ? "ok" : "FAILED", test_checks, test_errors);
    endtask

    always @(posedge clock) begin
        if (!rst_n) begin
            in_frame    = 1'b0;
            m_mode      = 1'b0;
            m_data      = '0;
            m_total     = '0;
            m_idx       = '0;
            m_sum       = '0;
            m_frames    = '0;
            m_beats     = '0;
            m_csum      = '0;
            s_start     = '0;
            s_length    = '0;
            s_mode      = 1'b0;
            ack_exp     = 1'b0;
            rd_wait     = 1'b0;
            held_valid  = 1'b0;
            rst_checked = 1'b0;
        end else begin
            // test boundaries
            if (test_id != prev_id) begin
                if (prev_id != 0) begin
                    report_test();
                end
                prev_id     = test_id;
                test_checks = 0;
                test_errors = 0;
                if (test_id != 0) begin
                    tests = tests + 1;
                end
            end
            if (!rst_checked) begin
                check_value("valid after reset", 32'd0, 32'(out_valid));
                rst_checked = 1'b1;
            end

            // slave acks once in the cycle after the request
            check_value("wishbone ack", 32'(ack_exp), 32'(wb_ack));
            // read data shows up with the ack
            if (rd_wait && ack_exp) begin
                check_value($sformatf("read %s", reg_name(rd_adr)), rd_exp, wb_dat_r);
                rd_wait = 1'b0;
            end
            // a pending request is served on this edge
            if (wb_req.cyc && wb_req.stb && !ack_exp) begin
                if (wb_req.we) begin
                    case (wb_req.adr)
                        `PG_REG_START:  s_start  = wb_req.dat;
                        `PG_REG_LENGTH: s_length = wb_req.dat;
                        `PG_REG_CTRL:   s_mode   = wb_req.dat[1];
                        default: ;
                    endcase
                end else begin
                    rd_adr  = wb_req.adr;
                    rd_exp  = expected_read(wb_req.adr);
                    rd_wait = 1'b1;
                end
                ack_exp = 1'b1;
            end else begin
                ack_exp = 1'b0;
            end

            // stalled beat must not move
            if (held_valid) begin
                check_value("stalled valid", 32'd1, 32'(out_valid));
                check_value("stalled data", held_beat.data, out_beat.data);
                check_value("stalled last", 32'(held_beat.last), 32'(out_beat.last));
                held_valid = 1'b0;
            end

            // first beat of a frame picks up the published config
            if (out_valid && !in_frame) begin
                if (!frame_expected) begin
                    report_fault("a beat appeared with no frame requested");
                end
                in_frame = 1'b1;
                m_mode   = frame_cfg.repeat_mode;
                m_data   = frame_cfg.start;
                m_total  = (frame_cfg.length < pg_len_t'(2)) ? pg_len_t'(1) : frame_cfg.length;
                m_idx    = '0;
            end

            if (out_valid && out_ready) begin
                exp_last = (m_idx == m_total - pg_len_t'(1));
                check_value("beat data", m_data, out_beat.data);
                check_value("beat last", 32'(exp_last), 32'(out_beat.last));
                sum_new = m_sum + m_data;
                m_beats = m_beats + 1;
                m_idx   = m_idx + 1;
                if (exp_last) begin
                    m_frames = m_frames + 1;
                    m_csum   = sum_new;
                    m_sum    = '0;
                    in_frame = 1'b0;
                end else begin
                    m_sum = sum_new;
                end
                // counting mode steps up by one modulo 2^32
                if (!m_mode) begin
                    m_data = m_data + 1;
                end
            end else if (out_valid) begin
                held_beat  = out_beat;
                held_valid = 1'b1;
            end
        end
    end

endmodule

// File: design/pattern_gen_top.sv
// pattern generator top
// register slave, sequence frame generator and frame monitor
// wishbone register port in, valid/ready frame stream out

module pattern_gen_top
    import pattern_gen_pkg::*;
(
    input  logic         clock,
    input  logic         rst_n,
    input  wb_req_t      wb_req,
    output logic         wb_ack,
    output pg_data_t     wb_dat_r,
    output stream_beat_t out_beat,
    output logic         out_valid,
    input  logic         out_ready
);

    // slave to generator
    gen_cfg_t cfg;
    logic     start_pulse;
    logic     idle_ready;

    // monitor to slave
    pg_data_t frame_count;
    pg_data_t beat_count;
    pg_data_t frame_csum;

    gen_csr_wb u_csr (
        .clock       (clock),
        .rst_n       (rst_n),
        .wb_req      (wb_req),
        .wb_ack      (wb_ack),
        .wb_dat_r    (wb_dat_r),
        .cfg         (cfg),
        .start_pulse (start_pulse),
        .idle_ready  (idle_ready),
        .frame_count (frame_count),
        .beat_count  (beat_count),
        .frame_csum  (frame_csum)
    );

    seq_frame_gen u_gen (
        .clock       (clock),
        .rst_n       (rst_n),
        .cfg         (cfg),
        .start_pulse (start_pulse),
        .idle_ready  (idle_ready),
        .out_beat    (out_beat),
        .out_valid   (out_valid),
        .out_ready   (out_ready)
    );

    // taps the same stream the consumer sees
    frame_monitor u_mon (
        .clock       (clock),
        .rst_n       (rst_n),
        .mon_beat    (out_beat),
        .mon_valid   (out_valid),
        .mon_ready   (out_ready),
        .frame_count (frame_count),
        .beat_count  (beat_count),
        .frame_csum  (frame_csum)
    );

endmodule

// File: design/frame_monitor.sv
// stream frame monitor
// counts accepted beats and frames on the generator output and keeps
// the data sum of the most recently finished frame

module frame_monitor
    import pattern_gen_pkg::*;
(
    input  logic         clock,
    input  logic         rst_n,
    input  stream_beat_t mon_beat,
    input  logic         mon_valid,
    input  logic         mon_ready,
    output pg_data_t     frame_count,
    output pg_data_t     beat_count,
    output pg_data_t     frame_csum
);

    // running sum of the frame in progress
    pg_data_t sum_acc;
    pg_data_t sum_next;
    logic     xfer;

    // passive, only looks at the handshake
    assign xfer     = mon_valid && mon_ready;
    assign sum_next = sum_acc + mon_beat.data;

    // beat counter, wraps modulo 2^32
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            beat_count <= '0;
        end else if (xfer) begin
            beat_count <= beat_count + pg_data_t'(1);
        end
    end

    // frame counter, one per last beat
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            frame_count <= '0;
        end else if (xfer && mon_beat.last) begin
            frame_count <= frame_count + pg_data_t'(1);
        end
    end

    // checksum accumulate
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            sum_acc    <= '0;
            frame_csum <= '0;
        end else if (xfer) begin
            if (mon_beat.last) begin
                // finished frame goes out, next one starts from zero
                frame_csum <= sum_next;
                sum_acc    <= '0;
            end else begin
                sum_acc <= sum_next;
            end
        end
    end

endmodule

// File: design/seq_frame_gen.sv
// sequence frame generator
// sends one frame per accepted start pulse on a valid/ready stream
// counting mode steps the data up by one per beat, repeat mode
// holds the start value; last marks the final beat of the frame

module seq_frame_gen
    import pattern_gen_pkg::*;
(
    input  logic         clock,
    input  logic         rst_n,
    input  gen_cfg_t     cfg,
    input  logic         start_pulse,
    output logic         idle_ready,
    output stream_beat_t out_beat,
    output logic         out_valid,
    input  logic         out_ready
);

    gen_state_e state;

    // frame settings held for the whole frame
    pg_len_t  lock_length;
    logic     lock_mode;

    // beats already sent in this frame
    pg_len_t  beat_cnt;
    pg_len_t  next_cnt;

    pg_data_t data_q;
    logic     last_q;

    logic     xfer;
    logic     launch;

    assign xfer     = out_valid && out_ready;
    // start only counts when idle and ready
    assign launch   = (state == GEN_IDLE) && idle_ready && start_pulse;
    assign next_cnt = beat_cnt + pg_len_t'(1);

    // control path
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            state       <= GEN_IDLE;
            idle_ready  <= 1'b0;
            out_valid   <= 1'b0;
            last_q      <= 1'b0;
            beat_cnt    <= '0;
            lock_length <= '0;
            lock_mode   <= 1'b0;
        end else begin
            case (state)
                GEN_IDLE: begin
                    // ready comes up one cycle after reset
                    idle_ready <= 1'b1;
                    if (launch) begin
                        state       <= GEN_SEND;
                        idle_ready  <= 1'b0;
                        out_valid   <= 1'b1;
                        beat_cnt    <= '0;
                        lock_length <= cfg.length;
                        lock_mode   <= cfg.repeat_mode;
                        // length 0 or 1 is a single beat
                        last_q      <= (cfg.length < pg_len_t'(2));
                    end
                end
                GEN_SEND: begin
                    if (xfer) begin
                        if (last_q) begin
                            // frame done, back to idle on this edge
                            state      <= GEN_IDLE;
                            idle_ready <= 1'b1;
                            out_valid  <= 1'b0;
                            last_q     <= 1'b0;
                        end else begin
                            beat_cnt <= next_cnt;
                            last_q   <= (next_cnt == lock_length - pg_len_t'(1));
                        end
                    end
                end
                default: begin
                    state <= GEN_IDLE;
                end
            endcase
        end
    end

    // payload, loaded at launch and stepped on each transfer
    always_ff @(posedge clock) begin
        if (launch) begin
            data_q <= cfg.start;
        end else if ((state == GEN_SEND) && xfer && !lock_mode) begin
            // wraps modulo 2^32
            data_q <= data_q + pg_data_t'(1);
        end
    end

    // beat holds still under back-pressure
    assign out_beat.data = data_q;
    assign out_beat.last = last_q;

endmodule

// File: design/gen_csr_wb.sv
// generator register slave
// wishbone classic slave holding start value, frame length and mode
// a go write to CTRL turns into a one-cycle start pulse
// also reads back generator status and monitor counters

`include "pattern_gen_config.svh"

module gen_csr_wb
    import pattern_gen_pkg::*;
(
    input  logic     clock,
    input  logic     rst_n,
    input  wb_req_t  wb_req,
    output logic     wb_ack,
    output pg_data_t wb_dat_r,
    output gen_cfg_t cfg,
    output logic     start_pulse,
    input  logic     idle_ready,
    input  pg_data_t frame_count,
    input  pg_data_t beat_count,
    input  pg_data_t frame_csum
);

    // configuration registers
    pg_data_t start_q;
    pg_len_t  length_q;
    logic     mode_q;

    logic     pending;
    logic     wr_en;
    logic     rd_en;
    pg_data_t rd_data;

    // request waiting for its ack
    assign pending = wb_req.cyc && wb_req.stb && !wb_ack;
    assign wr_en   = pending && wb_req.we;
    assign rd_en   = pending && !wb_req.we;

    // single-cycle ack, one cycle after the request shows up
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= pending;
        end
    end

    // register writes land on the same edge that raises ack
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            start_q     <= '0;
            length_q    <= '0;
            mode_q      <= 1'b0;
            start_pulse <= 1'b0;
        end else begin
            // pulse lasts one cycle by default
            start_pulse <= 1'b0;
            if (wr_en) begin
                case (wb_req.adr)
                    `PG_REG_START:  start_q  <= wb_req.dat;
                    `PG_REG_LENGTH: length_q <= wb_req.dat;
                    `PG_REG_CTRL: begin
                        mode_q      <= wb_req.dat[1];
                        // busy generator drops this itself
                        start_pulse <= wb_req.dat[0];
                    end
                    // status and counters are read only
                    default: ;
                endcase
            end
        end
    end

    // read mux
    always_comb begin
        case (wb_req.adr)
            `PG_REG_START:  rd_data = start_q;
            `PG_REG_LENGTH: rd_data = length_q;
            // go always reads back 0
            `PG_REG_CTRL:   rd_data = pg_data_t'({mode_q, 1'b0});
            `PG_REG_STATUS: rd_data = pg_data_t'(!idle_ready);
            `PG_REG_FRAMES: rd_data = frame_count;
            `PG_REG_BEATS:  rd_data = beat_count;
            `PG_REG_CSUM:   rd_data = frame_csum;
            default:        rd_data = '0;
        endcase
    end

    // read data valid while ack is high, zero otherwise
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            wb_dat_r <= '0;
        end else if (rd_en) begin
            wb_dat_r <= rd_data;
        end else begin
            wb_dat_r <= '0;
        end
    end

    // config goes straight to the generator
    assign cfg.start       = start_q;
    assign cfg.length      = length_q;
    assign cfg.repeat_mode = mode_q;

endmodule

// File: design/pattern_gen_pkg.sv
// pattern generator types
// data and address words, the stream beat, the wishbone request,
// the generator configuration and the generator state encoding

`include "pattern_gen_config.svh"

package pattern_gen_pkg;

    // one data or register word
    typedef logic [`PG_DATA_W-1:0] pg_data_t;
    // frame length in beats
    typedef logic [`PG_DATA_W-1:0] pg_len_t;
    // register word address
    typedef logic [`PG_ADDR_W-1:0] pg_addr_t;

    // one beat on the output stream
    typedef struct packed {
        pg_data_t data;
        logic     last;
    } stream_beat_t;

    // wishbone classic master to slave signals
    typedef struct packed {
        logic     cyc;
        logic     stb;
        logic     we;
        pg_addr_t adr;
        pg_data_t dat;
    } wb_req_t;

    // configuration seen by the generator
    typedef struct packed {
        pg_data_t start;
        pg_len_t  length;
        logic     repeat_mode;
    } gen_cfg_t;

    // generator fsm
    typedef enum logic {
        GEN_IDLE,
        GEN_SEND
    } gen_state_e;

endpackage

// File: design/pattern_gen_config.svh
// pattern generator configuration
// data width, register address width and register word addresses
// shared by the package and the register slave

`ifndef PATTERN_GEN_CONFIG_SVH
`define PATTERN_GEN_CONFIG_SVH

// stream data and wishbone data share one width
`define PG_DATA_W 32
// word address, seven registers in use
`define PG_ADDR_W 3

`define PG_REG_START  3'd0
`define PG_REG_LENGTH 3'd1
`define PG_REG_CTRL   3'd2
`define PG_REG_STATUS 3'd3
`define PG_REG_FRAMES 3'd4
`define PG_REG_BEATS  3'd5
`define PG_REG_CSUM   3'd6

`endif
